// File: rvfetch.f
+incdir+.
rvfetch_pkg.sv
pc_gen.sv
bus_arbiter.sv
bus_master_fsm.sv
latency_counter.sv
mem_slave.sv
if_stage.sv
tb_clkgen.sv
if_stage_tb.sv

// File: run_sim.sh
#!/bin/sh
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
  -f rvfetch.f --top-module if_stage_tb --Mdir obj_dir

./obj_dir/Vif_stage_tb > sim.log 2>&1
cat sim.log

if grep -q "TEST FAILED" sim.log; then
  echo "simulation reported failure"
  exit 1
fi
echo "simulation finished without failure"

// File: if_stage_tb.sv
`timescale 1ns/1ps
`include "rvfetch_defines.svh"

module if_stage_tb;
  import rvfetch_pkg::*;

  localparam int IDX_W     = $clog2(`MEM_WORDS);
  localparam int MAX_OPS   = 64;
  // start, address, wait, response
  localparam int XFER_CYC  = `MEM_LATENCY + 3;
  localparam int MEM_WAIT  = 40;
  localparam int INST_WAIT = 40;
  localparam int QUIET_CYC = 20;

  typedef enum logic [2:0] {
    OP_WRITE,
    OP_READ,
    OP_FETCH,
    OP_STALL,
    OP_REDIRECT,
    OP_MEM_MID
  } op_e;

  logic  clk;
  logic  rst_n;
  logic  stall_i;
  logic  redirect_valid_i;
  addr_t redirect_pc_i;
  logic  mem_valid_i;
  logic  mem_we_i;
  addr_t mem_addr_i;
  data_t mem_wdata_i;
  strb_t mem_wmask_i;
  logic  inst_valid_o;
  inst_t inst_o;
  addr_t inst_pc_o;
  data_t mem_rdata_o;
  logic  mem_done_o;

  // stimulus table
  op_e   op_kind  [MAX_OPS];
  addr_t op_addr  [MAX_OPS];
  data_t op_data  [MAX_OPS];
  strb_t op_mask  [MAX_OPS];
  int    op_count [MAX_OPS];
  int    n_ops;
  int    weight_sum;

  // reference memory
  data_t ref_mem [`MEM_WORDS];

  integer seed;
  int     mismatches;
  int     failures;
  int     cycle_cnt;
  int     cycle_limit;
  // fetch tracking
  addr_t  exp_pc;
  int     inst_seen;
  logic   fetch_open;
  int     late_left;
  // memory stage tracking
  logic   mem_pending;
  logic   mem_got;
  data_t  mem_rdata_got;

  tb_clkgen #(
    .PERIOD_NS  (10),
    .RST_CYCLES (10)
  ) u_clkgen (
    .clk_o   (clk),
    .rst_n_o (rst_n)
  );

  if_stage uut (
    .clk              (clk),
    .rst_n            (rst_n),
    .stall_i          (stall_i),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .mem_valid_i      (mem_valid_i),
    .mem_we_i         (mem_we_i),
    .mem_addr_i       (mem_addr_i),
    .mem_wdata_i      (mem_wdata_i),
    .mem_wmask_i      (mem_wmask_i),
    .inst_valid_o     (inst_valid_o),
    .inst_o           (inst_o),
    .inst_pc_o        (inst_pc_o),
    .mem_rdata_o      (mem_rdata_o),
    .mem_done_o       (mem_done_o)
  );

  // byte lanes with a set mask bit take the new data
  function automatic data_t merge_bytes(data_t old_w, data_t new_w, strb_t mask);
    data_t res;
    res = old_w;
    for (int b = 0; b < 8; b++) begin
      if (mask[b]) begin
        res[8*b +: 8] = new_w[8*b +: 8];
      end
    end
    return res;
  endfunction

  // pc bit 2 selects the upper instruction of the word
  function automatic inst_t model_inst(addr_t pc);
    data_t word;
    word = ref_mem[pc[IDX_W+2:3]];
    if (pc[2]) begin
      return word[`XLEN-1 -: `INST_W];
    end
    return word[`INST_W-1:0];
  endfunction

  task automatic add_op(op_e kind, addr_t addr, data_t data, strb_t mask, int count);
    op_kind[n_ops]  = kind;
    op_addr[n_ops]  = addr;
    op_data[n_ops]  = data;
    op_mask[n_ops]  = mask;
    op_count[n_ops] = count;
    n_ops           = n_ops + 1;
    weight_sum      = weight_sum + count;
  endtask

  task automatic build_table();
    data_t rnd;
    n_ops      = 0;
    weight_sum = 0;
    // code region, full random words
    for (int w = 0; w < 32; w++) begin
      rnd = {$random(seed), $random(seed)};
      add_op(OP_WRITE, `RESET_PC + addr_t'(8 * w), rnd, 8'hFF, 1);
    end
    rnd = {$random(seed), $random(seed)};
    add_op(OP_WRITE, 64'h40, rnd, 8'hFF, 1);
    rnd = {$random(seed), $random(seed)};
    add_op(OP_WRITE, 64'h48, rnd, 8'hFF, 1);
    // partial writes over them
    add_op(OP_WRITE, 64'h40, 64'h1122_3344_5566_7788, 8'h0F, 1);
    add_op(OP_WRITE, 64'h48, 64'hA5A5_5A5A_C3C3_3C3C, 8'hA5, 1);
    add_op(OP_WRITE, 64'h108, 64'hCAFE_F00D_0000_0000, 8'hF0, 1);
    add_op(OP_READ, 64'h40, '0, '0, 1);
    add_op(OP_READ, 64'h48, '0, '0, 1);
    add_op(OP_READ, 64'h108, '0, '0, 1);
    add_op(OP_READ, 64'h100, '0, '0, 1);
    // fetch scenarios
    add_op(OP_FETCH, `RESET_PC, '0, '0, 6);
    add_op(OP_STALL, '0, '0, '0, 6);
    add_op(OP_REDIRECT, 64'h1A4, '0, '0, 4);
    add_op(OP_MEM_MID, 64'h48, '0, '0, 4);
    add_op(OP_FETCH, 64'h1E0, '0, '0, 3);
  endtask

  task automatic check_inst();
    inst_t exp_inst;
    exp_inst = model_inst(exp_pc);
    if (!fetch_open) begin
      if (late_left > 0) begin
        late_left = late_left - 1;
      end else begin
        failures = failures + 1;
        $display("Error: instruction at pc %h reported while stalled", inst_pc_o);
      end
    end
    if (inst_pc_o !== exp_pc) begin
      mismatches = mismatches + 1;
      $display("Mismatch inst_pc_o: expected %h, got %h", exp_pc, inst_pc_o);
    end
    if (inst_o !== exp_inst) begin
      mismatches = mismatches + 1;
      $display("Mismatch inst_o at pc %h: expected %h, got %h", exp_pc, exp_inst, inst_o);
    end
    exp_pc    = exp_pc + addr_t'(4);
    inst_seen = inst_seen + 1;
  endtask

  // one cycle, outputs sampled on the falling edge
  task automatic step();
    @(negedge clk);
    if (inst_valid_o === 1'b1) begin
      check_inst();
    end
    if (mem_done_o === 1'b1) begin
      if (mem_pending && !mem_got) begin
        mem_got       = 1'b1;
        mem_rdata_got = mem_rdata_o;
      end else begin
        failures = failures + 1;
        $display("Error: mem_done_o pulsed with no memory request outstanding");
      end
    end
  endtask

  task automatic mem_access(logic we, addr_t addr, data_t wdata, strb_t mask);
    int    waited;
    data_t expect_data;
    mem_valid_i = 1'b1;
    mem_we_i    = we;
    mem_addr_i  = addr;
    mem_wdata_i = wdata;
    mem_wmask_i = mask;
    mem_pending = 1'b1;
    mem_got     = 1'b0;
    waited      = 0;
    while (!mem_got && waited < MEM_WAIT) begin
      step();
      waited = waited + 1;
    end
    mem_valid_i = 1'b0;
    mem_we_i    = 1'b0;
    mem_wmask_i = '0;
    mem_pending = 1'b0;
    if (!mem_got) begin
      failures = failures + 1;
      $display("Error: no mem_done_o pulse within %0d cycles for access at %h", MEM_WAIT, addr);
    end else if (we) begin
      ref_mem[addr[IDX_W+2:3]] = merge_bytes(ref_mem[addr[IDX_W+2:3]], wdata, mask);
    end else begin
      expect_data = ref_mem[addr[IDX_W+2:3]];
      if (mem_rdata_got !== expect_data) begin
        mismatches = mismatches + 1;
        $display("Mismatch mem_rdata_o at %h: expected %h, got %h",
                 addr, expect_data, mem_rdata_got);
      end
    end
    // valid low for a cycle so the next request counts as new
    step();
  endtask

  task automatic start_fetch();
    fetch_open = 1'b1;
    stall_i    = 1'b0;
  endtask

  // exactly the in-flight fetches still report, nothing new after them
  task automatic pause_fetch(int cycles, int in_flight);
    stall_i    = 1'b1;
    fetch_open = 1'b0;
    late_left  = in_flight;
    repeat (cycles) step();
    if (late_left != 0) begin
      failures = failures + 1;
      $display("Error: in-flight fetch did not complete while stalled");
    end
    late_left = 0;
  endtask

  task automatic collect(int n);
    int target;
    int waited;
    target = inst_seen + n;
    waited = 0;
    while (inst_seen < target && waited < n * INST_WAIT) begin
      step();
      waited = waited + 1;
    end
    if (inst_seen < target) begin
      failures = failures + 1;
      $display("Error: expected %0d instructions, only %0d reported",
               n, n - (target - inst_seen));
    end
  endtask

  task automatic redirect_pulse(addr_t target);
    redirect_valid_i = 1'b1;
    redirect_pc_i    = target;
    // anything reported from here on must be the new path
    exp_pc           = target;
    step();
    redirect_valid_i = 1'b0;
  endtask

  task automatic apply_op(int i);
    case (op_kind[i])
      OP_WRITE: mem_access(1'b1, op_addr[i], op_data[i], op_mask[i]);
      OP_READ: mem_access(1'b0, op_addr[i], '0, '0);
      OP_FETCH: begin
        redirect_pulse(op_addr[i]);
        start_fetch();
        collect(op_count[i]);
        pause_fetch(QUIET_CYC, 0);
      end
      OP_STALL: begin
        start_fetch();
        collect(op_count[i] / 2);
        // next fetch granted on this edge, stall lands while it is on the bus
        step();
        pause_fetch(QUIET_CYC, 1);
        start_fetch();
        collect(op_count[i] - op_count[i] / 2);
        pause_fetch(QUIET_CYC, 0);
      end
      OP_REDIRECT: begin
        start_fetch();
        collect(2);
        // next fetch granted on this edge, now on the bus
        step();
        redirect_pulse(op_addr[i]);
        collect(op_count[i]);
        pause_fetch(QUIET_CYC, 0);
      end
      OP_MEM_MID: begin
        start_fetch();
        collect(1);
        mem_access(1'b0, op_addr[i], '0, '0);
        collect(op_count[i]);
        pause_fetch(QUIET_CYC, 0);
      end
      default: begin
        failures = failures + 1;
        $display("Error: unknown operation in table entry %0d", i);
      end
    endcase
  endtask

  initial begin
    stall_i          = 1'b1;
    redirect_valid_i = 1'b0;
    redirect_pc_i    = '0;
    mem_valid_i      = 1'b0;
    mem_we_i         = 1'b0;
    mem_addr_i       = '0;
    mem_wdata_i      = '0;
    mem_wmask_i      = '0;
    seed             = 57828;
    mismatches       = 0;
    failures         = 0;
    exp_pc           = `RESET_PC;
    inst_seen        = 0;
    fetch_open       = 1'b0;
    late_left        = 0;
    mem_pending      = 1'b0;
    mem_got          = 1'b0;
    mem_rdata_got    = '0;
    for (int w = 0; w < `MEM_WORDS; w++) begin
      ref_mem[w] = '0;
    end
    build_table();
    cycle_limit = 20 * weight_sum * XFER_CYC;
    @(posedge rst_n);
    // stalled out of reset, nothing may come back
    repeat (QUIET_CYC) step();
    for (int i = 0; i < n_ops; i++) begin
      apply_op(i);
    end
    $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
    if (mismatches == 0 && failures == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

  // watchdog
  initial begin
    cycle_cnt = 0;
    @(posedge rst_n);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk);
      cycle_cnt = cycle_cnt + 1;
    end
    $display("Error: run did not finish within %0d cycles", cycle_limit);
    $display("TEST FAILED");
    $finish;
  end

endmodule

// File: tb_clkgen.sv
`timescale 1ns/1ps

module tb_clkgen #(
  parameter int PERIOD_NS  = 10,
  parameter int RST_CYCLES = 10
) (
  output logic clk_o,
  output logic rst_n_o
);

  // free running clock
  initial begin
    clk_o = 1'b0;
    forever #(PERIOD_NS / 2) clk_o = ~clk_o;
  end

  // reset released on a falling edge, clear of the sampling edge
  initial begin
    rst_n_o = 1'b0;
    repeat (RST_CYCLES) @(posedge clk_o);
    @(negedge clk_o);
    rst_n_o = 1'b1;
  end

endmodule

// File: if_stage.sv
`timescale 1ns/1ps
`include "rvfetch_defines.svh"

module if_stage (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               stall_i,
  input  logic               redirect_valid_i,
  input  rvfetch_pkg::addr_t redirect_pc_i,
  input  logic               mem_valid_i,
  input  logic               mem_we_i,
  input  rvfetch_pkg::addr_t mem_addr_i,
  input  rvfetch_pkg::data_t mem_wdata_i,
  input  rvfetch_pkg::strb_t mem_wmask_i,
  output logic               inst_valid_o,
  output rvfetch_pkg::inst_t inst_o,
  output rvfetch_pkg::addr_t inst_pc_o,
  output rvfetch_pkg::data_t mem_rdata_o,
  output logic               mem_done_o
);
  import rvfetch_pkg::*;

  // fetch side
  logic     fetch_req;
  addr_t    fetch_pc;
  logic     epoch;
  logic     if_grant;
  logic     mem_grant;
  logic     if_done;
  logic     mem_done;
  // arbiter to master
  logic     bus_req;
  logic     bus_we;
  addr_t    bus_addr;
  data_t    bus_wdata;
  strb_t    bus_wmask;
  req_src_e bus_src;
  logic     bus_idle;
  logic     bus_done;
  data_t    bus_rdata;
  req_src_e done_src;
  // master to slave
  logic     ar_valid;
  addr_t    ar_addr;
  logic     ar_ready;
  logic     r_valid;
  logic     r_ready;
  data_t    r_data;
  logic     aw_valid;
  addr_t    aw_addr;
  data_t    w_data;
  strb_t    w_strb;
  logic     aw_ready;
  logic     b_valid;
  logic     b_ready;
  // fetch in flight
  addr_t    if_pc_q;
  logic     if_epoch_q;
  // output registers
  logic     inst_valid_q;
  inst_t    inst_q;
  addr_t    inst_pc_q;
  logic     mem_done_q;
  data_t    mem_rdata_q;

  assign if_done  = bus_done & (done_src == SRC_IF);
  assign mem_done = bus_done & (done_src == SRC_MEM);

  pc_gen u_pc_gen (
    .clk              (clk),
    .rst_n            (rst_n),
    .stall_i          (stall_i),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .grant_i          (if_grant),
    .done_i           (if_done),
    .fetch_req_o      (fetch_req),
    .fetch_pc_o       (fetch_pc),
    .epoch_o          (epoch)
  );

  bus_arbiter u_arbiter (
    .clk         (clk),
    .rst_n       (rst_n),
    .fetch_req_i (fetch_req),
    .fetch_pc_i  (fetch_pc),
    .mem_valid_i (mem_valid_i),
    .mem_we_i    (mem_we_i),
    .mem_addr_i  (mem_addr_i),
    .mem_wdata_i (mem_wdata_i),
    .mem_wmask_i (mem_wmask_i),
    .bus_idle_i  (bus_idle),
    .if_grant_o  (if_grant),
    .mem_grant_o (mem_grant),
    .bus_req_o   (bus_req),
    .bus_we_o    (bus_we),
    .bus_addr_o  (bus_addr),
    .bus_wdata_o (bus_wdata),
    .bus_wmask_o (bus_wmask),
    .bus_src_o   (bus_src)
  );

  bus_master_fsm u_master (
    .clk         (clk),
    .rst_n       (rst_n),
    .bus_req_i   (bus_req),
    .bus_we_i    (bus_we),
    .bus_addr_i  (bus_addr),
    .bus_wdata_i (bus_wdata),
    .bus_wmask_i (bus_wmask),
    .bus_src_i   (bus_src),
    .ar_ready_i  (ar_ready),
    .r_valid_i   (r_valid),
    .r_data_i    (r_data),
    .aw_ready_i  (aw_ready),
    .b_valid_i   (b_valid),
    .bus_idle_o  (bus_idle),
    .bus_done_o  (bus_done),
    .bus_rdata_o (bus_rdata),
    .done_src_o  (done_src),
    .ar_valid_o  (ar_valid),
    .ar_addr_o   (ar_addr),
    .r_ready_o   (r_ready),
    .aw_valid_o  (aw_valid),
    .aw_addr_o   (aw_addr),
    .w_data_o    (w_data),
    .w_strb_o    (w_strb),
    .b_ready_o   (b_ready)
  );

  mem_slave u_mem (
    .clk        (clk),
    .rst_n      (rst_n),
    .ar_valid_i (ar_valid),
    .ar_addr_i  (ar_addr),
    .r_ready_i  (r_ready),
    .aw_valid_i (aw_valid),
    .aw_addr_i  (aw_addr),
    .w_data_i   (w_data),
    .w_strb_i   (w_strb),
    .b_ready_i  (b_ready),
    .ar_ready_o (ar_ready),
    .r_valid_o  (r_valid),
    .r_data_o   (r_data),
    .aw_ready_o (aw_ready),
    .b_valid_o  (b_valid)
  );

  // pc and epoch of the fetch on the bus
  always_ff @(posedge clk) begin
    if (if_grant) begin
      if_pc_q    <= fetch_pc;
      if_epoch_q <= epoch;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      inst_valid_q <= 1'b0;
      inst_q       <= `NOP_INST;
      mem_done_q   <= 1'b0;
    end else begin
      // stale epoch, fetch was made before a redirect
      inst_valid_q <= if_done & (if_epoch_q == epoch);
      mem_done_q   <= mem_done;
      if (if_done) begin
        // pc bit 2 picks the half of the word
        inst_q <= if_pc_q[2] ? bus_rdata[`XLEN-1 -: `INST_W] : bus_rdata[`INST_W-1:0];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (if_done) begin
      inst_pc_q <= if_pc_q;
    end
    if (mem_done) begin
      mem_rdata_q <= bus_rdata;
    end
  end

  assign inst_valid_o = inst_valid_q;
  assign inst_o       = inst_q;
  assign inst_pc_o    = inst_pc_q;
  assign mem_done_o   = mem_done_q;
  assign mem_rdata_o  = mem_rdata_q;

  // grant, start, address, wait, response, done, output register
  a_mem_turnaround: assert property (@(posedge clk) disable iff (!rst_n)
    mem_grant |-> ##(`MEM_LATENCY + 5) mem_done_o)
    else $error("if_stage: memory request did not complete on time");

endmodule

// File: mem_slave.sv
`timescale 1ns/1ps
`include "rvfetch_defines.svh"

module mem_slave (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               ar_valid_i,
  input  rvfetch_pkg::addr_t ar_addr_i,
  input  logic               r_ready_i,
  input  logic               aw_valid_i,
  input  rvfetch_pkg::addr_t aw_addr_i,
  input  rvfetch_pkg::data_t w_data_i,
  input  rvfetch_pkg::strb_t w_strb_i,
  input  logic               b_ready_i,
  output logic               ar_ready_o,
  output logic               r_valid_o,
  output rvfetch_pkg::data_t r_data_o,
  output logic               aw_ready_o,
  output logic               b_valid_o
);
  import rvfetch_pkg::*;

  localparam int IDX_W = $clog2(`MEM_WORDS);

  data_t             mem [`MEM_WORDS];
  data_t             rdata_q;
  logic [IDX_W-1:0]  rd_idx;
  logic [IDX_W-1:0]  wr_idx;
  logic              busy_q;
  logic              is_wr_q;
  logic              r_valid_q;
  logic              b_valid_q;
  logic              ar_hs;
  logic              aw_hs;
  logic              r_hs;
  logic              b_hs;
  logic              expired;

  // 64-bit words, byte offset in bits 2:0
  assign rd_idx = ar_addr_i[IDX_W+2:3];
  assign wr_idx = aw_addr_i[IDX_W+2:3];

  // read address wins if both show up together
  assign ar_ready_o = ~busy_q;
  assign aw_ready_o = ~busy_q & ~ar_valid_i;

  assign ar_hs = ar_valid_i & ar_ready_o;
  assign aw_hs = aw_valid_i & aw_ready_o;
  assign r_hs  = r_valid_q & r_ready_i;
  assign b_hs  = b_valid_q & b_ready_i;

  latency_counter u_latency (
    .clk       (clk),
    .rst_n     (rst_n),
    .start_i   (ar_hs | aw_hs),
    .expired_o (expired)
  );

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy_q    <= 1'b0;
      is_wr_q   <= 1'b0;
      r_valid_q <= 1'b0;
      b_valid_q <= 1'b0;
    end else begin
      if (ar_hs) begin
        busy_q  <= 1'b1;
        is_wr_q <= 1'b0;
      end else if (aw_hs) begin
        busy_q  <= 1'b1;
        is_wr_q <= 1'b1;
      end else if (r_hs || b_hs) begin
        busy_q <= 1'b0;
      end
      // response held until the master takes it
      if (expired && !is_wr_q) begin
        r_valid_q <= 1'b1;
      end else if (r_hs) begin
        r_valid_q <= 1'b0;
      end
      if (expired && is_wr_q) begin
        b_valid_q <= 1'b1;
      end else if (b_hs) begin
        b_valid_q <= 1'b0;
      end
    end
  end

  // write lands at the address handshake, only masked bytes
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      for (int b = 0; b < 8; b++) begin
        if (w_strb_i[b]) begin
          mem[wr_idx][8*b +: 8] <= w_data_i[8*b +: 8];
        end
      end
    end
    if (ar_hs) begin
      rdata_q <= mem[rd_idx];
    end
  end

  assign r_valid_o = r_valid_q;
  assign r_data_o  = rdata_q;
  assign b_valid_o = b_valid_q;

endmodule

// File: latency_counter.sv
`timescale 1ns/1ps
`include "rvfetch_defines.svh"

module latency_counter (
  input  logic clk,
  input  logic rst_n,
  input  logic start_i,
  output logic expired_o
);

  logic [`LAT_W-1:0] cnt_q;

  // zero means idle
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      cnt_q <= '0;
    end else if (start_i) begin
      cnt_q <= `LAT_W'(`MEM_LATENCY);
    end else if (cnt_q != '0) begin
      cnt_q <= cnt_q - 1'b1;
    end
  end

  // last wait cycle, count hits zero on this edge
  assign expired_o = (cnt_q == `LAT_W'd1);

endmodule

// File: bus_master_fsm.sv
`timescale 1ns/1ps

module bus_master_fsm (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  bus_req_i,
  input  logic                  bus_we_i,
  input  rvfetch_pkg::addr_t    bus_addr_i,
  input  rvfetch_pkg::data_t    bus_wdata_i,
  input  rvfetch_pkg::strb_t    bus_wmask_i,
  input  rvfetch_pkg::req_src_e bus_src_i,
  input  logic                  ar_ready_i,
  input  logic                  r_valid_i,
  input  rvfetch_pkg::data_t    r_data_i,
  input  logic                  aw_ready_i,
  input  logic                  b_valid_i,
  output logic                  bus_idle_o,
  output logic                  bus_done_o,
  output rvfetch_pkg::data_t    bus_rdata_o,
  output rvfetch_pkg::req_src_e done_src_o,
  output logic                  ar_valid_o,
  output rvfetch_pkg::addr_t    ar_addr_o,
  output logic                  r_ready_o,
  output logic                  aw_valid_o,
  output rvfetch_pkg::addr_t    aw_addr_o,
  output rvfetch_pkg::data_t    w_data_o,
  output rvfetch_pkg::strb_t    w_strb_o,
  output logic                  b_ready_o
);
  import rvfetch_pkg::*;

  bus_state_e state_q;
  bus_state_e state_d;
  logic       done_q;
  data_t      rdata_q;
  // latched copy of the request
  addr_t      addr_q;
  data_t      wdata_q;
  strb_t      strb_q;
  req_src_e   src_q;

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE: begin
        if (bus_req_i) begin
          state_d = bus_we_i ? ST_AW_W : ST_AR;
        end
      end
      ST_AR: begin
        if (ar_ready_i) begin
          state_d = ST_R;
        end
      end
      // r_ready is tied high, valid alone completes
      ST_R: begin
        if (r_valid_i) begin
          state_d = ST_IDLE;
        end
      end
      ST_AW_W: begin
        if (aw_ready_i) begin
          state_d = ST_B;
        end
      end
      ST_B: begin
        if (b_valid_i) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state_q <= ST_IDLE;
      done_q  <= 1'b0;
    end else begin
      state_q <= state_d;
      // one-cycle pulse after the response handshake
      done_q  <= (state_q == ST_R && r_valid_i) || (state_q == ST_B && b_valid_i);
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == ST_IDLE && bus_req_i) begin
      addr_q  <= bus_addr_i;
      wdata_q <= bus_wdata_i;
      strb_q  <= bus_wmask_i;
      src_q   <= bus_src_i;
    end
    if (state_q == ST_R && r_valid_i) begin
      rdata_q <= r_data_i;
    end
  end

  assign bus_idle_o  = (state_q == ST_IDLE);
  assign bus_done_o  = done_q;
  assign bus_rdata_o = rdata_q;
  // src_q is stable until the next start, which comes after done
  assign done_src_o  = src_q;

  // channel drive straight from the state
  assign ar_valid_o = (state_q == ST_AR);
  assign ar_addr_o  = addr_q;
  assign r_ready_o  = 1'b1;
  assign aw_valid_o = (state_q == ST_AW_W);
  assign aw_addr_o  = addr_q;
  assign w_data_o   = wdata_q;
  assign w_strb_o   = strb_q;
  assign b_ready_o  = 1'b1;

  // arbiter must only start a transfer on an idle master
  a_req_in_idle: assert property (@(posedge clk) disable iff (!rst_n)
    bus_req_i |-> state_q == ST_IDLE)
    else $error("bus_master_fsm: start pulse while busy");

endmodule

// File: bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  fetch_req_i,
  input  rvfetch_pkg::addr_t    fetch_pc_i,
  input  logic                  mem_valid_i,
  input  logic                  mem_we_i,
  input  rvfetch_pkg::addr_t    mem_addr_i,
  input  rvfetch_pkg::data_t    mem_wdata_i,
  input  rvfetch_pkg::strb_t    mem_wmask_i,
  input  logic                  bus_idle_i,
  output logic                  if_grant_o,
  output logic                  mem_grant_o,
  output logic                  bus_req_o,
  output logic                  bus_we_o,
  output rvfetch_pkg::addr_t    bus_addr_o,
  output rvfetch_pkg::data_t    bus_wdata_o,
  output rvfetch_pkg::strb_t    bus_wmask_o,
  output rvfetch_pkg::req_src_e bus_src_o
);
  import rvfetch_pkg::*;

  logic     bus_req_q;
  logic     bus_we_q;
  addr_t    bus_addr_q;
  data_t    bus_wdata_q;
  strb_t    bus_wmask_q;
  req_src_e bus_src_q;
  // current mem request already served, wait for a new one
  logic     mem_taken_q;
  logic     can_issue;

  // master still reads idle in the cycle of the start pulse
  assign can_issue = bus_idle_i & ~bus_req_q;

  // memory stage first
  assign mem_grant_o = can_issue & mem_valid_i & ~mem_taken_q;
  assign if_grant_o  = can_issue & fetch_req_i & ~mem_grant_o;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      bus_req_q   <= 1'b0;
      mem_taken_q <= 1'b0;
    end else begin
      bus_req_q <= mem_grant_o | if_grant_o;
      if (!mem_valid_i) begin
        mem_taken_q <= 1'b0;
      end else if (mem_grant_o) begin
        mem_taken_q <= 1'b1;
      end
    end
  end

  // request payload, only loaded on a grant
  always_ff @(posedge clk) begin
    if (mem_grant_o) begin
      bus_we_q    <= mem_we_i;
      bus_addr_q  <= mem_addr_i;
      bus_wdata_q <= mem_wdata_i;
      bus_wmask_q <= mem_wmask_i;
      bus_src_q   <= SRC_MEM;
    end else if (if_grant_o) begin
      bus_we_q    <= 1'b0;
      bus_addr_q  <= fetch_pc_i;
      bus_wdata_q <= '0;
      bus_wmask_q <= '0;
      bus_src_q   <= SRC_IF;
    end
  end

  assign bus_req_o   = bus_req_q;
  assign bus_we_o    = bus_we_q;
  assign bus_addr_o  = bus_addr_q;
  assign bus_wdata_o = bus_wdata_q;
  assign bus_wmask_o = bus_wmask_q;
  assign bus_src_o   = bus_src_q;

  // pc_gen drops its request once granted, until the fetch returns
  a_fetch_req_drop: assert property (@(posedge clk) disable iff (!rst_n)
    if_grant_o |=> !fetch_req_i)
    else $error("bus_arbiter: fetch request held after its grant");

endmodule

// File: pc_gen.sv
`timescale 1ns/1ps
`include "rvfetch_defines.svh"

module pc_gen (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               stall_i,
  input  logic               redirect_valid_i,
  input  rvfetch_pkg::addr_t redirect_pc_i,
  input  logic               grant_i,
  input  logic               done_i,
  output logic               fetch_req_o,
  output rvfetch_pkg::addr_t fetch_pc_o,
  output logic               epoch_o
);
  import rvfetch_pkg::*;

  addr_t pc_q;
  // low during reset and for the first clock after it
  logic  run_q;
  // a fetch has been granted and not yet returned
  logic  wait_q;
  // returning fetch belongs to the old path
  logic  drop_q;
  logic  epoch_q;
  logic  inflight;

  // the done cycle itself no longer counts as in flight
  assign inflight = wait_q & ~done_i;

  // no request in a redirect cycle, it would fetch the old path
  assign fetch_req_o = run_q & ~wait_q & ~stall_i & ~redirect_valid_i;
  assign fetch_pc_o  = pc_q;
  assign epoch_o     = epoch_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc_q    <= `RESET_PC;
      run_q   <= 1'b0;
      wait_q  <= 1'b0;
      drop_q  <= 1'b0;
      epoch_q <= 1'b0;
    end else begin
      run_q <= 1'b1;
      if (grant_i) begin
        wait_q <= 1'b1;
      end else if (done_i) begin
        wait_q <= 1'b0;
      end
      // redirect wins over the sequential step
      if (redirect_valid_i) begin
        pc_q <= redirect_pc_i;
      end else if (done_i && !drop_q) begin
        pc_q <= pc_q + addr_t'(4);
      end
      if (done_i) begin
        drop_q <= 1'b0;
      end else if (redirect_valid_i && inflight) begin
        drop_q <= 1'b1;
      end
      // one toggle per flight, a second redirect keeps the mismatch
      if (redirect_valid_i && inflight && !drop_q) begin
        epoch_q <= ~epoch_q;
      end
    end
  end

  // redirect targets from execute are word aligned too
  a_pc_aligned: assert property (@(posedge clk) disable iff (!rst_n)
    pc_q[1:0] == 2'b00)
    else $error("pc_gen: pc not 4-byte aligned");

endmodule

// File: rvfetch_pkg.sv
`include "rvfetch_defines.svh"

package rvfetch_pkg;

  // byte address and bus data word
  typedef logic [`XLEN-1:0] addr_t;
  typedef logic [`XLEN-1:0] data_t;

  typedef logic [`INST_W-1:0] inst_t;

  // one bit per byte lane of data_t
  typedef logic [7:0] strb_t;

  // who owns the transfer on the bus
  typedef enum logic {
    SRC_IF  = 1'b0,
    SRC_MEM = 1'b1
  } req_src_e;

  // bus master states
  typedef enum logic [2:0] {
    ST_IDLE = 3'd0,
    ST_AR   = 3'd1,
    ST_R    = 3'd2,
    ST_AW_W = 3'd3,
    ST_B    = 3'd4
  } bus_state_e;

endpackage

// File: rvfetch_defines.svh
`ifndef RVFETCH_DEFINES_SVH
`define RVFETCH_DEFINES_SVH

// datapath and address width
`define XLEN 64

// one rv instruction
`define INST_W 32

// first fetch address out of reset
`define RESET_PC 64'h0000_0000_0000_0100

// addi x0, x0, 0
`define NOP_INST 32'h0000_0013

// on-chip memory depth in 64-bit words
`define MEM_WORDS 256

// slave wait cycles after an address handshake
`define MEM_LATENCY 3

// timer width, must hold MEM_LATENCY
`define LAT_W 4

`endif
